// ==== flist.f ====
+incdir+.
zest_pkg.sv
zest_mem_if.sv
zest_bus_fabric.sv
zest_sfr.sv
zest_awg_mem.sv
zest_awg_player.sv
zest_dac_src.sv
zest_dac_top.sv
tb_zest_dac.sv

// ==== tb_zest_dac.sv ====
`timescale 1ns/10ps
`include "zest_defines.svh"

module tb_zest_dac;
    import zest_pkg::*;

    localparam int BUS_TIMEOUT = 20;
    localparam int N_ONESHOT   = 16;
    localparam int N_LOOP      = 12;

    logic        dac_clk_out;
    logic        reset_i;
    logic        mem_valid_i;
    bus_addr_t   mem_addr_i;
    bus_data_t   mem_wdata_i;
    bus_strb_t   mem_wstrb_i;
    logic        mem_ready_o;
    bus_data_t   mem_rdata_o;
    dac_sample_t dac_data_i_i;
    dac_sample_t dac_data_q_i;
    dac_sample_t dac_i_o;
    dac_sample_t dac_q_o;
    logic        dac_reset_o;
    logic        pwr_en_o;

    logic [31:0] lfsr_state;
    // Model of the sample RAM contents
    dac_sample_t exp_mem [`ZEST_AWG_DEPTH];

    zest_dac_top u_zest_dac_top (.*);

    // 125 MHz DAC clock
    initial begin
        dac_clk_out = 1'b0;
        forever #4 dac_clk_out = ~dac_clk_out;
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    task automatic report_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
            report_failure();
        end
    endtask

    // Galois LFSR, taps x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Zero would hide in the playback bubbles
    function automatic dac_sample_t nonzero_sample();
        dac_sample_t s;
        s = dac_sample_t'(take_bits($bits(dac_sample_t)));
        if (s == '0) begin
            s = 14'h1;
        end
        return s;
    endfunction

    function automatic bus_addr_t reg_addr(input logic [7:0] region, input logic [13:0] word);
        return {`ZEST_BASE_ADDR, region, word, 2'b00};
    endfunction

    // Requests start on a falling edge, one idle cycle between them
    task automatic bus_write(input bus_addr_t addr, input bus_data_t data,
                             input bus_strb_t strb, input int exp_cycles);
        int cycles;
        @(negedge dac_clk_out);
        mem_valid_i = 1'b1;
        mem_addr_i  = addr;
        mem_wdata_i = data;
        mem_wstrb_i = strb;
        cycles      = 0;
        do begin
            @(negedge dac_clk_out);
            cycles++;
        end while (!mem_ready_o && cycles < BUS_TIMEOUT);
        if (!mem_ready_o) begin
            $display("Timeout: bus write to %h never got ready", addr);
            report_failure();
        end
        mem_valid_i = 1'b0;
        mem_wstrb_i = '0;
        check(cycles, exp_cycles, $sformatf("write ready latency at %h", addr));
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data,
                            input int exp_cycles);
        int cycles;
        @(negedge dac_clk_out);
        mem_valid_i = 1'b1;
        mem_addr_i  = addr;
        mem_wstrb_i = '0;
        cycles      = 0;
        do begin
            @(negedge dac_clk_out);
            cycles++;
        end while (!mem_ready_o && cycles < BUS_TIMEOUT);
        if (!mem_ready_o) begin
            $display("Timeout: bus read from %h never got ready", addr);
            report_failure();
        end
        data        = mem_rdata_o;
        mem_valid_i = 1'b0;
        check(cycles, exp_cycles, $sformatf("read ready latency at %h", addr));
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic after_reset();
        bus_data_t rd;
        check(dac_reset_o, 1'b0, "dac_reset_o after reset");
        check(pwr_en_o, 1'b1, "pwr_en_o after reset");
        check(dac_i_o, '0, "dac_i_o after reset");
        check(dac_q_o, '0, "dac_q_o after reset");
        check(mem_ready_o, 1'b0, "mem_ready_o after reset");
        bus_read(reg_addr(`ZEST_REG_SFR, `ZEST_SFR_OUT0), rd, 1);
        check(rd, '0, "OUT0 reset value");
        bus_read(reg_addr(`ZEST_REG_SFR, `ZEST_SFR_OUT1), rd, 1);
        check(rd, '0, "OUT1 reset value");
        bus_read(reg_addr(`ZEST_REG_AWG_CTRL, `ZEST_AWG_LEN), rd, 1);
        check(rd, `ZEST_AWG_DEPTH, "LEN reset value");
        // Wrong board base, then wrong region
        bus_read({8'h06, `ZEST_REG_SFR, 16'h0000}, rd, 1);
        check(rd, '0, "unmapped base read");
        bus_read(reg_addr(8'h31, 14'd0), rd, 1);
        check(rd, '0, "unmapped region read");
        bus_write(reg_addr(8'h31, 14'd5), 32'hdead_beef, 4'hf, 1);
    endtask

    task automatic sfr_strobes();
        bus_data_t rd;
        bus_addr_t a0;
        bus_addr_t a1;
        a0 = reg_addr(`ZEST_REG_SFR, `ZEST_SFR_OUT0);
        a1 = reg_addr(`ZEST_REG_SFR, `ZEST_SFR_OUT1);
        // Byte 0 not strobed, nothing changes
        bus_write(a0, 32'h0000_0003, 4'b1110, 1);
        bus_read(a0, rd, 1);
        check(rd, 32'h0, "OUT0 unstrobed write");
        check(dac_reset_o, 1'b0, "dac_reset_o unstrobed");
        check(pwr_en_o, 1'b1, "pwr_en_o unstrobed");
        bus_write(a0, 32'hffff_ff01, 4'b0001, 1);
        bus_read(a0, rd, 1);
        check(rd, 32'h1, "OUT0 reset bit");
        check(dac_reset_o, 1'b1, "dac_reset_o set");
        check(pwr_en_o, 1'b1, "pwr_en_o with bit 1 clear");
        bus_write(a0, 32'h0000_0002, 4'b0001, 1);
        bus_read(a0, rd, 1);
        check(rd, 32'h2, "OUT0 power bit");
        check(dac_reset_o, 1'b0, "dac_reset_o cleared");
        check(pwr_en_o, 1'b0, "pwr_en_o inverted");
        // Unused bits read back zero
        bus_write(a0, 32'hffff_ffff, 4'hf, 1);
        bus_read(a0, rd, 1);
        check(rd, 32'h3, "OUT0 all ones");
        check(dac_reset_o, 1'b1, "dac_reset_o all ones");
        check(pwr_en_o, 1'b0, "pwr_en_o all ones");
        bus_write(a1, 32'h0000_000f, 4'b1110, 1);
        bus_read(a1, rd, 1);
        check(rd, 32'h0, "OUT1 unstrobed write");
        bus_write(a1, 32'hffff_ffff, 4'hf, 1);
        bus_read(a1, rd, 1);
        check(rd, 32'hf, "OUT1 all ones");
        bus_write(a0, 32'h0, 4'hf, 1);
        bus_write(a1, 32'h0, 4'hf, 1);
    endtask

    task automatic sample_mem_rw();
        bus_data_t rd;
        int        a;
        // Upper data bits random, must not come back
        for (a = 0; a < `ZEST_AWG_DEPTH; a++) begin
            exp_mem[a] = nonzero_sample();
            bus_write(reg_addr(`ZEST_REG_AWG_MEM, 14'(a)),
                      {18'(take_bits(18)), exp_mem[a]}, 4'hf, 2);
        end
        for (a = 0; a < `ZEST_AWG_DEPTH; a++) begin
            bus_read(reg_addr(`ZEST_REG_AWG_MEM, 14'(a)), rd, 2);
            check(rd, {18'b0, exp_mem[a]}, $sformatf("sample readback at %0d", a));
        end
    endtask

    // Live words pass one output register
    task automatic stream_live(input int n, input logic en_i, input logic en_q);
        dac_sample_t prev_i;
        dac_sample_t prev_q;
        int          c;
        @(negedge dac_clk_out);
        prev_i = dac_data_i_i;
        prev_q = dac_data_q_i;
        for (c = 0; c < n; c++) begin
            @(negedge dac_clk_out);
            check(dac_i_o, en_i ? prev_i : '0, "live I word");
            check(dac_q_o, en_q ? prev_q : '0, "live Q word");
            dac_data_i_i = dac_sample_t'(take_bits(14));
            dac_data_q_i = dac_sample_t'(take_bits(14));
            prev_i       = dac_data_i_i;
            prev_q       = dac_data_q_i;
        end
    endtask

    task automatic live_path();
        bus_addr_t a1;
        a1 = reg_addr(`ZEST_REG_SFR, `ZEST_SFR_OUT1);
        // Both enabled, both live
        bus_write(a1, 32'ha, 4'h1, 1);
        stream_live(20, 1'b1, 1'b1);
        bus_write(a1, 32'h2, 4'h1, 1);
        stream_live(20, 1'b1, 1'b0);
        bus_write(a1, 32'h8, 4'h1, 1);
        stream_live(10, 1'b0, 1'b1);
    endtask

    task automatic one_shot_play();
        bus_data_t   rd;
        dac_sample_t exp;
        int          c;
        bus_write(reg_addr(`ZEST_REG_SFR, `ZEST_SFR_OUT1), 32'hf, 4'h1, 1);
        bus_write(reg_addr(`ZEST_REG_AWG_CTRL, `ZEST_AWG_LEN), N_ONESHOT, 4'hf, 1);
        // Returns on the negedge after the start edge
        bus_write(reg_addr(`ZEST_REG_AWG_CTRL, `ZEST_AWG_CTRL), 32'h1, 4'h1, 1);
        for (c = 1; c <= N_ONESHOT + 6; c++) begin
            @(negedge dac_clk_out);
            exp = (c >= 3 && c < 3 + N_ONESHOT) ? exp_mem[c-3] : '0;
            check(dac_i_o, exp, $sformatf("one-shot I, cycle %0d", c));
            check(dac_q_o, exp, $sformatf("one-shot Q, cycle %0d", c));
        end
        bus_read(reg_addr(`ZEST_REG_AWG_CTRL, `ZEST_AWG_STAT), rd, 1);
        check(rd, 32'h0, "STAT after one-shot");
    endtask

    task automatic loop_play();
        bus_data_t rd;
        int        pos;
        int        seen;
        int        j;
        pos  = 0;
        seen = 0;
        bus_write(reg_addr(`ZEST_REG_AWG_CTRL, `ZEST_AWG_LEN), N_LOOP, 4'hf, 1);
        fork
            begin
                // Start with loop, then mix STAT and sample reads
                bus_write(reg_addr(`ZEST_REG_AWG_CTRL, `ZEST_AWG_CTRL), 32'h3, 4'h1, 1);
                for (j = 0; j < 6; j++) begin
                    bus_read(reg_addr(`ZEST_REG_AWG_CTRL, `ZEST_AWG_STAT), rd, 1);
                    check(rd, 32'h1, "STAT busy while looping");
                    bus_read(reg_addr(`ZEST_REG_AWG_MEM, 14'(j * 7)), rd, 2);
                    check(rd, {18'b0, exp_mem[j*7]}, "sample read during playback");
                end
            end
            begin
                // Bubbles are zero, skip them
                repeat (90) begin
                    @(negedge dac_clk_out);
                    check(dac_q_o, dac_i_o, "loop Q follows I");
                    if (dac_i_o != '0) begin
                        check(dac_i_o, exp_mem[pos], $sformatf("loop sample %0d", pos));
                        pos = (pos + 1) % N_LOOP;
                        seen++;
                    end
                end
            end
        join
        check(seen > 2 * N_LOOP, 1'b1, "loop wrapped at least twice");
        bus_write(reg_addr(`ZEST_REG_AWG_CTRL, `ZEST_AWG_CTRL), 32'h4, 4'h1, 1);
        bus_read(reg_addr(`ZEST_REG_AWG_CTRL, `ZEST_AWG_STAT), rd, 1);
        check(rd, 32'h0, "STAT after stop");
        repeat (6) @(negedge dac_clk_out);
        check(dac_i_o, '0, "I idle after stop");
        check(dac_q_o, '0, "Q idle after stop");
    endtask

    // ------------------------------
    // Sequence
    // ------------------------------

    initial begin
        lfsr_state   = 32'h19da2525;
        reset_i      = 1'b1;
        mem_valid_i  = 1'b0;
        mem_addr_i   = '0;
        mem_wdata_i  = '0;
        mem_wstrb_i  = '0;
        dac_data_i_i = '0;
        dac_data_q_i = '0;
        repeat (8) @(negedge dac_clk_out);
        reset_i = 1'b0;

        after_reset();
        sfr_strobes();
        sample_mem_rw();
        live_path();
        one_shot_play();
        loop_play();

        // Any failed check has already stopped the run
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== zest_awg_mem.sv ====
`timescale 1ns/10ps
`include "zest_defines.svh"

module zest_awg_mem (
    input  logic                  clk,
    input  logic                  reset_i,
    zest_mem_if.slave             bus,
    input  logic                  rd_req_i,
    input  zest_pkg::awg_addr_t   rd_addr_i,
    output zest_pkg::dac_sample_t rd_data_o,
    output logic                  rd_valid_o
);
    import zest_pkg::*;

    dac_sample_t ram [`ZEST_AWG_DEPTH];
    dac_sample_t ram_q;
    awg_addr_t   ram_addr;
    logic        bus_gnt;
    logic        ply_gnt;
    logic        bus_wr;
    // Bus access one cycle into the RAM
    logic        bus_pend;

    // ------------------------------
    // Arbiter
    // ------------------------------

    // Bus wins, once per request
    assign bus_gnt = bus.valid & ~bus_pend & ~bus.ready;
    // Player gets the port when the bus leaves it free
    assign ply_gnt = rd_req_i & ~bus_gnt;
    assign bus_wr  = bus_gnt & (bus.wstrb != '0);

    // Word address from the bus
    assign ram_addr = bus_gnt ? bus.addr[2 +: `ZEST_AWG_DEPTH_LOG2] : rd_addr_i;

    // ------------------------------
    // Single-port RAM
    // ------------------------------

    // Whole sample written on any strobe
    always_ff @(posedge clk) begin
        if (bus_wr) begin
            ram[ram_addr] <= bus.wdata[$bits(dac_sample_t)-1:0];
        end
        ram_q <= ram[ram_addr];
    end

    // Player data straight off the RAM
    assign rd_data_o = ram_q;

    // Bus reply two cycles after valid
    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus_pend   <= 1'b0;
            rd_valid_o <= 1'b0;
            bus.ready  <= 1'b0;
            bus.rdata  <= '0;
        end else begin
            bus_pend   <= bus_gnt;
            rd_valid_o <= ply_gnt;
            bus.ready  <= bus_pend;
            // Sample in the low 14 bits, rest zero
            bus.rdata  <= bus_pend ? bus_data_t'(ram_q) : '0;
        end
    end

    // A player read that loses the port comes back at the same index
    a_grant_excl : assert property (@(posedge clk) disable iff (reset_i)
        (rd_req_i && bus_gnt) |=> (rd_req_i && (rd_addr_i == $past(rd_addr_i))));

endmodule

// ==== zest_awg_player.sv ====
`timescale 1ns/10ps
`include "zest_defines.svh"

module zest_awg_player (
    input  logic                  clk,
    input  logic                  reset_i,
    zest_mem_if.slave             bus,
    output logic                  rd_req_o,
    output zest_pkg::awg_addr_t   rd_addr_o,
    input  logic                  rd_valid_i,
    input  zest_pkg::dac_sample_t rd_data_i,
    output zest_pkg::dac_sample_t awg_data_o,
    output logic                  awg_valid_o
);
    import zest_pkg::*;

    // Sample count, 1 to depth
    typedef logic [`ZEST_AWG_DEPTH_LOG2:0] len_t;

    awg_state_t state;
    awg_addr_t  idx;
    awg_addr_t  last_idx;
    len_t       len;
    logic       loop_en;
    logic       issued;
    logic       stall;
    logic       last;
    logic       acc;
    logic       wr;
    logic       hit_ctrl;
    logic       hit_len;
    logic       hit_stat;
    logic       start_req;
    logic       stop_req;
    bus_data_t  rd_word;

    // ------------------------------
    // Control registers
    // ------------------------------

    assign acc       = bus.valid & ~bus.ready;
    assign wr        = acc & (bus.wstrb != '0);
    assign hit_ctrl  = (bus.addr[15:2] == `ZEST_AWG_CTRL);
    assign hit_len   = (bus.addr[15:2] == `ZEST_AWG_LEN);
    assign hit_stat  = (bus.addr[15:2] == `ZEST_AWG_STAT);
    // Start and stop are pulses, never stored
    assign start_req = wr & hit_ctrl & bus.wstrb[0] & bus.wdata[0];
    assign stop_req  = wr & hit_ctrl & bus.wstrb[0] & bus.wdata[2];

    always_comb begin
        rd_word = '0;
        if (hit_ctrl) begin
            rd_word[1] = loop_en;
        end
        if (hit_len) begin
            rd_word[`ZEST_AWG_DEPTH_LOG2:0] = len;
        end
        if (hit_stat) begin
            rd_word[0] = (state == AWG_RUN);   // busy
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bus.ready <= 1'b0;
            bus.rdata <= '0;
            loop_en   <= 1'b0;
            len       <= len_t'(`ZEST_AWG_DEPTH);
        end else begin
            bus.ready <= acc;
            bus.rdata <= (acc && !wr) ? rd_word : '0;
            if (wr && hit_ctrl && bus.wstrb[0]) begin
                loop_en <= bus.wdata[1];
            end
            if (wr && hit_len) begin
                len <= bus.wdata[`ZEST_AWG_DEPTH_LOG2:0];
            end
        end
    end

    // ------------------------------
    // Sample fetch FSM
    // ------------------------------

    // Last cycle's read lost arbitration
    assign stall     = issued & ~rd_valid_i;
    assign last      = (len_t'(idx) == len - 1'b1);
    // Retry the lost index before anything new
    assign rd_req_o  = (state == AWG_RUN) | stall;
    assign rd_addr_o = stall ? last_idx : idx;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state    <= AWG_IDLE;
            idx      <= '0;
            last_idx <= '0;
            issued   <= 1'b0;
        end else begin
            issued   <= rd_req_o;
            last_idx <= rd_addr_o;
            case (state)
                AWG_IDLE: begin
                    idx <= '0;
                    if (start_req && !stop_req) begin
                        state <= AWG_RUN;
                    end
                end
                AWG_RUN: begin
                    if (stop_req) begin
                        state <= AWG_IDLE;
                        idx   <= '0;
                    end else if (!stall) begin
                        if (!last) begin
                            idx <= idx + 1'b1;
                        end else begin
                            // Wrap, or end of one-shot
                            idx <= '0;
                            if (!loop_en) begin
                                state <= AWG_IDLE;
                            end
                        end
                    end
                end
                default: state <= AWG_IDLE;
            endcase
        end
    end

    // Stream is the RAM output, marked by the grant
    assign awg_data_o  = rd_data_i;
    assign awg_valid_o = rd_valid_i;

    // Issued index stays inside the programmed length
    a_idx_range : assert property (@(posedge clk) disable iff (reset_i)
        rd_req_o |-> (len_t'(rd_addr_o) < len));

endmodule

// ==== zest_bus_fabric.sv ====
`timescale 1ns/10ps
`include "zest_defines.svh"

module zest_bus_fabric (
    input  logic       clk,
    input  logic       reset_i,
    zest_mem_if.slave  mst,
    zest_mem_if.master sfr_bus,
    zest_mem_if.master ctrl_bus,
    zest_mem_if.master smem_bus
);

    logic base_hit;
    logic sel_sfr;
    logic sel_ctrl;
    logic sel_mem;
    logic sel_none;
    logic dflt_ready;

    // ------------------------------
    // Region decode
    // ------------------------------

    assign base_hit = (mst.addr[31:24] == `ZEST_BASE_ADDR);
    assign sel_sfr  = base_hit && (mst.addr[23:16] == `ZEST_REG_SFR);
    assign sel_ctrl = base_hit && (mst.addr[23:16] == `ZEST_REG_AWG_CTRL);
    assign sel_mem  = base_hit && (mst.addr[23:16] == `ZEST_REG_AWG_MEM);
    // Anything else goes to the default responder
    assign sel_none = !(sel_sfr || sel_ctrl || sel_mem);

    // Request fan-out, valid reaches one peer only
    assign sfr_bus.valid  = mst.valid & sel_sfr;
    assign sfr_bus.addr   = mst.addr;
    assign sfr_bus.wdata  = mst.wdata;
    assign sfr_bus.wstrb  = mst.wstrb;

    assign ctrl_bus.valid = mst.valid & sel_ctrl;
    assign ctrl_bus.addr  = mst.addr;
    assign ctrl_bus.wdata = mst.wdata;
    assign ctrl_bus.wstrb = mst.wstrb;

    assign smem_bus.valid = mst.valid & sel_mem;
    assign smem_bus.addr  = mst.addr;
    assign smem_bus.wdata = mst.wdata;
    assign smem_bus.wstrb = mst.wstrb;

    // ------------------------------
    // Default responder
    // ------------------------------

    // One-cycle ready for unmapped addresses, so the CPU never hangs
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dflt_ready <= 1'b0;
        end else begin
            dflt_ready <= mst.valid & sel_none & ~dflt_ready;
        end
    end

    // Idle peers drive zero, so a plain OR merges the replies
    // Default rdata is zero as well
    assign mst.ready = sfr_bus.ready | ctrl_bus.ready | smem_bus.ready | dflt_ready;
    assign mst.rdata = sfr_bus.rdata | ctrl_bus.rdata | smem_bus.rdata;

    // Only the addressed region answers
    a_one_region : assert property (@(posedge clk) disable iff (reset_i)
        $onehot0({sfr_bus.ready, ctrl_bus.ready, smem_bus.ready, dflt_ready}));

endmodule

// ==== zest_dac_src.sv ====
`timescale 1ns/10ps

module zest_dac_src (
    input  logic                  clk,
    input  logic                  reset_i,
    input  zest_pkg::dac_sample_t awg_data_i,
    input  logic                  awg_valid_i,
    input  zest_pkg::dac_sample_t dac_data_i_i,
    input  zest_pkg::dac_sample_t dac_data_q_i,
    input  logic                  dac0_enable_i,
    input  logic                  dac0_src_sel_i,
    input  logic                  dac1_enable_i,
    input  logic                  dac1_src_sel_i,
    output zest_pkg::dac_sample_t dac_i_o,
    output zest_pkg::dac_sample_t dac_q_o
);
    import zest_pkg::*;

    // AWG word after the pipeline stage
    dac_sample_t awg_q;

    // Channel mux: src 1 is AWG, disabled gives zero
    function automatic dac_sample_t pick(input logic en, input logic src,
                                         input dac_sample_t awg, input dac_sample_t live);
        dac_sample_t s;
        s = src ? awg : live;
        return en ? s : '0;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            awg_q   <= '0;
            dac_i_o <= '0;
            dac_q_o <= '0;
        end else begin
            // Gaps in the stream become zero
            awg_q   <= awg_valid_i ? awg_data_i : '0;
            // DAC0 is I, DAC1 is Q
            dac_i_o <= pick(dac0_enable_i, dac0_src_sel_i, awg_q, dac_data_i_i);
            dac_q_o <= pick(dac1_enable_i, dac1_src_sel_i, awg_q, dac_data_q_i);
        end
    end

endmodule

// ==== zest_dac_top.sv ====
`timescale 1ns/10ps

module zest_dac_top (
    input  logic                  dac_clk_out,
    input  logic                  reset_i,
    // Processor memory bus
    input  logic                  mem_valid_i,
    input  zest_pkg::bus_addr_t   mem_addr_i,
    input  zest_pkg::bus_data_t   mem_wdata_i,
    input  zest_pkg::bus_strb_t   mem_wstrb_i,
    output logic                  mem_ready_o,
    output zest_pkg::bus_data_t   mem_rdata_o,
    // Live I/Q and registered DAC words
    input  zest_pkg::dac_sample_t dac_data_i_i,
    input  zest_pkg::dac_sample_t dac_data_q_i,
    output zest_pkg::dac_sample_t dac_i_o,
    output zest_pkg::dac_sample_t dac_q_o,
    output logic                  dac_reset_o,
    output logic                  pwr_en_o
);
    import zest_pkg::*;

    awg_addr_t   rd_addr;
    dac_sample_t rd_data;
    dac_sample_t awg_data;
    logic        rd_req;
    logic        rd_valid;
    logic        awg_valid;
    logic        dac0_enable;
    logic        dac0_src_sel;
    logic        dac1_enable;
    logic        dac1_src_sel;

    // ------------------------------
    // Bus
    // ------------------------------

    zest_mem_if mst_if ();
    zest_mem_if sfr_if ();
    zest_mem_if ctrl_if ();
    zest_mem_if smem_if ();

    assign mst_if.valid = mem_valid_i;
    assign mst_if.addr  = mem_addr_i;
    assign mst_if.wdata = mem_wdata_i;
    assign mst_if.wstrb = mem_wstrb_i;
    assign mem_ready_o  = mst_if.ready;
    assign mem_rdata_o  = mst_if.rdata;

    zest_bus_fabric u_fabric (
        .clk      (dac_clk_out),
        .reset_i  (reset_i),
        .mst      (mst_if),
        .sfr_bus  (sfr_if),
        .ctrl_bus (ctrl_if),
        .smem_bus (smem_if)
    );

    // ------------------------------
    // Peers
    // ------------------------------

    zest_sfr u_sfr (
        .clk            (dac_clk_out),
        .reset_i        (reset_i),
        .bus            (sfr_if),
        .dac_reset_o    (dac_reset_o),
        .pwr_en_o       (pwr_en_o),
        .dac0_enable_o  (dac0_enable),
        .dac0_src_sel_o (dac0_src_sel),
        .dac1_enable_o  (dac1_enable),
        .dac1_src_sel_o (dac1_src_sel)
    );

    zest_awg_mem u_awg_mem (
        .clk        (dac_clk_out),
        .reset_i    (reset_i),
        .bus        (smem_if),
        .rd_req_i   (rd_req),
        .rd_addr_i  (rd_addr),
        .rd_data_o  (rd_data),
        .rd_valid_o (rd_valid)
    );

    zest_awg_player u_awg_player (
        .clk         (dac_clk_out),
        .reset_i     (reset_i),
        .bus         (ctrl_if),
        .rd_req_o    (rd_req),
        .rd_addr_o   (rd_addr),
        .rd_valid_i  (rd_valid),
        .rd_data_i   (rd_data),
        .awg_data_o  (awg_data),
        .awg_valid_o (awg_valid)
    );

    // Source select and output registers
    zest_dac_src u_dac_src (
        .clk            (dac_clk_out),
        .reset_i        (reset_i),
        .awg_data_i     (awg_data),
        .awg_valid_i    (awg_valid),
        .dac_data_i_i   (dac_data_i_i),
        .dac_data_q_i   (dac_data_q_i),
        .dac0_enable_i  (dac0_enable),
        .dac0_src_sel_i (dac0_src_sel),
        .dac1_enable_i  (dac1_enable),
        .dac1_src_sel_i (dac1_src_sel),
        .dac_i_o        (dac_i_o),
        .dac_q_o        (dac_q_o)
    );

endmodule

// ==== zest_defines.svh ====
`ifndef ZEST_DEFINES_SVH
`define ZEST_DEFINES_SVH

// ------------------------------
// Address map
// ------------------------------

// Board base, compared with addr[31:24]
`define ZEST_BASE_ADDR      8'h05

// Region codes, compared with addr[23:16]
`define ZEST_REG_SFR        8'h20
`define ZEST_REG_AWG_CTRL   8'h23
`define ZEST_REG_AWG_MEM    8'h24

// ------------------------------
// Register word offsets
// ------------------------------

// SFR region, addr[15:2]
`define ZEST_SFR_OUT0       14'd0
`define ZEST_SFR_OUT1       14'd1

// AWG control region, addr[15:2]
`define ZEST_AWG_CTRL       14'd0
`define ZEST_AWG_LEN        14'd1
`define ZEST_AWG_STAT       14'd2

// ------------------------------
// Sample memory
// ------------------------------

// 256 samples
`define ZEST_AWG_DEPTH_LOG2 8
`define ZEST_AWG_DEPTH      (1 << `ZEST_AWG_DEPTH_LOG2)

`endif

// ==== zest_mem_if.sv ====
`timescale 1ns/10ps

interface zest_mem_if;
    import zest_pkg::*;

    // Request side, held stable while valid is high
    logic      valid;
    bus_addr_t addr;
    bus_data_t wdata;
    bus_strb_t wstrb;

    // Reply side, one-cycle ready pulse
    logic      ready;
    bus_data_t rdata;

    // Processor or fabric request port
    modport master (output valid, addr, wdata, wstrb, input ready, rdata);

    // Peer side
    modport slave (input valid, addr, wdata, wstrb, output ready, rdata);

    // Passive observer
    modport monitor (input valid, addr, wdata, wstrb, ready, rdata);

endinterface

// ==== zest_pkg.sv ====
`include "zest_defines.svh"

package zest_pkg;

    // ------------------------------
    // Memory bus words
    // ------------------------------

    // Byte address
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    // One strobe per byte lane, all zero on a read
    typedef logic [3:0]  bus_strb_t;

    // ------------------------------
    // DAC data path
    // ------------------------------

    // AD9781 code width
    typedef logic [13:0] dac_sample_t;
    // Sample memory index
    typedef logic [`ZEST_AWG_DEPTH_LOG2-1:0] awg_addr_t;

    // Player FSM
    typedef enum logic {
        AWG_IDLE,
        AWG_RUN
    } awg_state_t;

endpackage

// ==== zest_sfr.sv ====
`timescale 1ns/10ps
`include "zest_defines.svh"

module zest_sfr (
    input  logic      clk,
    input  logic      reset_i,
    zest_mem_if.slave bus,
    output logic      dac_reset_o,
    output logic      pwr_en_o,
    output logic      dac0_enable_o,
    output logic      dac0_src_sel_o,
    output logic      dac1_enable_o,
    output logic      dac1_src_sel_o
);
    import zest_pkg::*;

    // OUT0: bit 0 DAC reset, bit 1 power enable bar
    logic [1:0] out0;
    // OUT1: {dac1_en, dac1_src, dac0_en, dac0_src}
    logic [3:0] out1;
    logic       acc;
    logic       wr;
    logic       hit0;
    logic       hit1;
    bus_data_t  rd_word;

    // First cycle of a request
    assign acc  = bus.valid & ~bus.ready;
    assign wr   = acc & (bus.wstrb != '0);
    assign hit0 = (bus.addr[15:2] == `ZEST_SFR_OUT0);
    assign hit1 = (bus.addr[15:2] == `ZEST_SFR_OUT1);

    // Readback, unused bits zero
    always_comb begin
        rd_word = '0;
        if (hit0) begin
            rd_word[1:0] = out0;
        end
        if (hit1) begin
            rd_word[3:0] = out1;
        end
    end

    // ------------------------------
    // Register file
    // ------------------------------

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out0      <= '0;
            out1      <= '0;
            bus.ready <= 1'b0;
            bus.rdata <= '0;
        end else begin
            bus.ready <= acc;
            bus.rdata <= (acc && !wr) ? rd_word : '0;
            // All stored bits sit in byte lane 0
            if (wr && bus.wstrb[0]) begin
                if (hit0) begin
                    out0 <= bus.wdata[1:0];
                end
                if (hit1) begin
                    out1 <= bus.wdata[3:0];
                end
            end
        end
    end

    // Pin levels
    assign dac_reset_o    = out0[0];
    assign pwr_en_o       = ~out0[1];   // stored active low
    assign dac0_src_sel_o = out1[0];
    assign dac0_enable_o  = out1[1];
    assign dac1_src_sel_o = out1[2];
    assign dac1_enable_o  = out1[3];

endmodule
